// File: Makefile
# Verilator build and run of the pat testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
		--top-module pat_tb -Mdir obj_dir -o pat_sim
	./obj_dir/pat_sim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: common/pat_pkg.sv
`default_nettype none

package pat_pkg;

	// ======================================================================
	// widths
	// ======================================================================
	localparam int instr_width = 20; // one instruction word
	localparam int data_width = 8; // accumulator and data memory word
	localparam int pc_width = 10; // instruction address
	localparam int dmem_adr_width = 4; // 16 data words actually decoded

	// field positions inside the instruction word
	localparam int cond_lsb = 13; // condition at 14..13
	localparam int opc8_lsb = 8; // i8 opcode at 11..8, immediate at 7..0
	localparam int opc3_lsb = 4; // i3 opcode at 7..4
	localparam int opc0_lsb = 0; // i0 opcode at 3..0
	localparam int imm3_width = 3; // i3 immediate at 2..0

	// escape value, i8 space -> i3 space and i3 space -> i0 space
	localparam logic [3:0] prefix_ext = 4'b1111;

	// i8 opcodes
	localparam logic [3:0] opc8_or = 4'h0;
	localparam logic [3:0] opc8_and = 4'h1;
	localparam logic [3:0] opc8_addm = 4'h2;
	localparam logic [3:0] opc8_subm = 4'h3;
	localparam logic [3:0] opc8_add = 4'h4;
	localparam logic [3:0] opc8_sub = 4'h5;
	localparam logic [3:0] opc8_ldi = 4'h6;
	localparam logic [3:0] opc8_ldm = 4'h7;
	localparam logic [3:0] opc8_bf = 4'h8;
	localparam logic [3:0] opc8_stm = 4'hb;
	localparam logic [3:0] opc8_orm = 4'hd;
	localparam logic [3:0] opc8_andm = 4'he;

	// i3 opcodes
	localparam logic [3:0] opc3_shl = 4'h0;
	localparam logic [3:0] opc3_shlo = 4'h1;
	localparam logic [3:0] opc3_shr = 4'h2;
	localparam logic [3:0] opc3_asr = 4'h3;
	localparam logic [3:0] opc3_out = 4'h8;

	// i0 opcodes
	localparam logic [3:0] opc0_not = 4'h0;
	localparam logic [3:0] opc0_test = 4'h2;
	localparam logic [3:0] opc0_nop = 4'hf;

	// ======================================================================
	// types
	// ======================================================================
	typedef logic [instr_width-1:0] instr_t;
	typedef logic [data_width-1:0] data_t;
	typedef logic [pc_width-1:0] pc_t;

	// branch condition, both upper codes mean always
	typedef enum logic [1:0] {
		cond_zero = 2'b00,
		cond_neg = 2'b01,
		cond_always = 2'b10,
		cond_always_alt = 2'b11
	} cond_e;

	// decoded operation, one per kept instruction
	typedef enum logic [4:0] {
		op_or, op_and, op_add, op_sub,
		op_addm, op_subm, op_orm, op_andm,
		op_ldi, op_ldm, op_stm, op_bf,
		op_shl, op_shlo, op_shr, op_asr, op_out,
		op_not, op_test, op_nop,
		op_bad // unused encoding, runs as nop
	} op_e;

	localparam instr_t nop_word = 20'h06ff5; // escape, escape, always

endpackage

`default_nettype wire

// File: fetch/pat_fetch.sv
`default_nettype none

module pat_fetch #(
	parameter int imem_depth = 256
) (
	input wire clk,
	input wire reset,
	// load port, written while reset is held
	input wire i_imem_wr_en,
	input wire pat_pkg::pc_t i_imem_wr_addr,
	input wire pat_pkg::instr_t i_imem_wr_data,
	// towards decode
	input wire i_ready,
	output logic o_valid,
	output pat_pkg::instr_t o_instr,
	output pat_pkg::pc_t o_pc,
	// branch redirect from execute
	input wire i_redirect,
	input wire pat_pkg::pc_t i_target
);
	import pat_pkg::*;

	localparam int imem_adr_width = $clog2(imem_depth); // low pc bits that index the array

	instr_t imem [imem_depth]; // program store
	pc_t pc; // address of the next word to fetch
	logic advance; // output register free or being taken

	assign advance = !o_valid || i_ready;

	// load port, no handshake
	always_ff @(posedge clk)
	begin
		if (i_imem_wr_en)
			imem[i_imem_wr_addr[imem_adr_width-1:0]] <= i_imem_wr_data;
	end

	// ======================================================================
	// pc and valid
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			o_valid <= 1'b0;
		end
		else if (i_redirect)
		begin
			pc <= i_target; // taken bf, restart at target
			o_valid <= 1'b0; // held word is on the wrong path
		end
		else if (advance)
		begin
			pc <= pc + 1'b1;
			o_valid <= 1'b1;
		end
	end

	// fetched word and its address
	always_ff @(posedge clk)
	begin
		if (i_redirect)
			o_instr <= nop_word; // squashed slot reads as a nop
		else if (advance)
		begin
			o_instr <= imem[pc[imem_adr_width-1:0]];
			o_pc <= pc;
		end
	end

	// one bubble after a redirect and the target word right behind it
	a_redirect_bubble : assert property (
		@(posedge clk) disable iff (reset)
		$past(i_redirect, 2) |-> (!$past(o_valid) && o_valid && o_pc == $past(i_target, 2))
	);

endmodule

`default_nettype wire

// File: list.f
+incdir+test
common/pat_pkg.sv
fetch/pat_fetch.sv
source/pat_data_mem.sv
source/pat_alu.sv
source/pat_decode.sv
source/pat_execute.sv
source/pat_core.sv
test/pat_tb.sv

// File: source/pat_alu.sv
`default_nettype none

module pat_alu (
	input wire pat_pkg::data_t i_a, // accumulator
	input wire pat_pkg::data_t i_b, // immediate or memory word
	input wire pat_pkg::op_e i_op,
	output pat_pkg::data_t o_y
);
	import pat_pkg::*;

	logic [2:0] sh; // shift amount
	data_t ones_mask; // low sh bits set, for shlo

	assign sh = i_b[2:0];
	assign ones_mask = ~({data_width{1'b1}} << sh);

	always_comb
	begin
		case (i_op)
			// logic, the m-forms share the register forms
			op_or, op_orm: o_y = i_a | i_b;
			op_and, op_andm: o_y = i_a & i_b;
			op_not: o_y = ~i_a;
			// arithmetic wraps at data_width
			op_add, op_addm: o_y = i_a + i_b;
			op_sub, op_subm: o_y = i_a - i_b;
			// shifts
			op_shl: o_y = i_a << sh;
			op_shlo: o_y = (i_a << sh) | ones_mask; // vacated bits filled with ones
			op_shr: o_y = i_a >> sh;
			op_asr: o_y = data_t'($signed(i_a) >>> sh); // sign bit kept
			// loads pass the operand
			op_ldi, op_ldm: o_y = i_b;
			default: o_y = i_a; // ops that do not write the accumulator
		endcase
	end

endmodule

`default_nettype wire

// File: source/pat_core.sv
`default_nettype none

module pat_core #(
	parameter int imem_depth = 256,
	parameter int dmem_depth = 16
) (
	input wire clk,
	input wire reset,
	input wire i_imem_wr_en,
	input wire pat_pkg::pc_t i_imem_wr_addr,
	input wire pat_pkg::instr_t i_imem_wr_data,
	input wire i_out_ready,
	output logic o_out_valid,
	output pat_pkg::data_t o_out_data
);
	import pat_pkg::*;

	// fetch -> decode
	logic f_valid, f_ready;
	instr_t f_instr;
	pc_t f_pc;
	// decode -> execute
	logic d_valid, d_ready;
	op_e d_op;
	cond_e d_cond;
	data_t d_imm, d_mem_data;
	pc_t d_pc;
	// redirect and memory
	logic x_redirect;
	pc_t x_target;
	logic x_wr_en;
	logic [dmem_adr_width-1:0] x_wr_adr, mem_radr;
	data_t x_wr_data, mem_rdata;

	pat_fetch #(.imem_depth(imem_depth)) u_fetch (
		.clk(clk), .reset(reset),
		.i_imem_wr_en(i_imem_wr_en), .i_imem_wr_addr(i_imem_wr_addr),
		.i_imem_wr_data(i_imem_wr_data),
		.i_ready(f_ready), .o_valid(f_valid), .o_instr(f_instr), .o_pc(f_pc),
		.i_redirect(x_redirect), .i_target(x_target)
	);

	pat_decode u_decode (
		.clk(clk), .reset(reset),
		.i_valid(f_valid), .o_ready(f_ready), .i_instr(f_instr), .i_pc(f_pc),
		.i_ready(d_ready), .o_valid(d_valid), .o_op(d_op), .o_cond(d_cond),
		.o_imm(d_imm), .o_mem_data(d_mem_data), .o_pc(d_pc),
		.i_flush(x_redirect), .o_mem_radr(mem_radr), .i_mem_rdata(mem_rdata)
	);

	pat_data_mem #(.dmem_depth(dmem_depth)) u_dmem (
		.clk(clk), .i_radr(mem_radr), .i_wr_en(x_wr_en), .i_wr_adr(x_wr_adr),
		.i_wr_data(x_wr_data), .o_rdata(mem_rdata)
	);

	pat_execute u_execute (
		.clk(clk), .reset(reset),
		.i_valid(d_valid), .o_ready(d_ready), .i_op(d_op), .i_cond(d_cond),
		.i_imm(d_imm), .i_mem_data(d_mem_data), .i_pc(d_pc),
		.o_redirect(x_redirect), .o_target(x_target),
		.o_wr_en(x_wr_en), .o_wr_adr(x_wr_adr), .o_wr_data(x_wr_data),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .i_out_ready(i_out_ready)
	);

endmodule

`default_nettype wire

// File: source/pat_data_mem.sv
`default_nettype none

module pat_data_mem #(
	parameter int dmem_depth = 16
) (
	input wire clk,
	input wire [pat_pkg::dmem_adr_width-1:0] i_radr,
	input wire i_wr_en,
	input wire [pat_pkg::dmem_adr_width-1:0] i_wr_adr,
	input wire pat_pkg::data_t i_wr_data,
	output pat_pkg::data_t o_rdata
);
	import pat_pkg::*;

	data_t mem [dmem_depth];

	// asynchronous read, a write landing this edge is seen already
	assign o_rdata = (i_wr_en && (i_wr_adr == i_radr)) ? i_wr_data : mem[i_radr];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr] <= i_wr_data;
	end

	// a store must carry the accumulator of a fully reset core
	a_wr_data_known : assert property (@(posedge clk) i_wr_en |-> !$isunknown(i_wr_data));

endmodule

`default_nettype wire

// File: source/pat_decode.sv
`default_nettype none

module pat_decode (
	input wire clk,
	input wire reset,
	// from fetch
	input wire i_valid,
	output logic o_ready,
	input wire pat_pkg::instr_t i_instr,
	input wire pat_pkg::pc_t i_pc,
	// to execute
	input wire i_ready,
	output logic o_valid,
	output pat_pkg::op_e o_op,
	output pat_pkg::cond_e o_cond,
	output pat_pkg::data_t o_imm,
	output pat_pkg::data_t o_mem_data,
	output pat_pkg::pc_t o_pc,
	// squash from a taken branch
	input wire i_flush,
	// data memory read
	output logic [pat_pkg::dmem_adr_width-1:0] o_mem_radr,
	input wire pat_pkg::data_t i_mem_rdata
);
	import pat_pkg::*;

	logic [3:0] opc8; // i8 opcode field
	logic [3:0] opc3; // i3 opcode field, overlaps the i8 immediate
	logic [3:0] opc0; // i0 opcode field
	logic is_i8;
	logic is_i3;
	op_e op_next;
	data_t imm_next;
	logic uses_mem; // m-forms and ldm read the data memory
	logic load; // take a word from fetch this cycle

	assign opc8 = i_instr[opc8_lsb +: 4];
	assign opc3 = i_instr[opc3_lsb +: 4];
	assign opc0 = i_instr[opc0_lsb +: 4];

	// class by the escape prefixes
	assign is_i8 = (opc8 != prefix_ext);
	assign is_i3 = !is_i8 && (opc3 != prefix_ext); // otherwise i0

	// ======================================================================
	// opcode map
	// ======================================================================
	always_comb
	begin
		op_next = op_bad;
		if (is_i8)
		begin
			case (opc8)
				opc8_or: op_next = op_or;
				opc8_and: op_next = op_and;
				opc8_addm: op_next = op_addm;
				opc8_subm: op_next = op_subm;
				opc8_add: op_next = op_add;
				opc8_sub: op_next = op_sub;
				opc8_ldi: op_next = op_ldi;
				opc8_ldm: op_next = op_ldm;
				opc8_bf: op_next = op_bf;
				opc8_stm: op_next = op_stm;
				opc8_orm: op_next = op_orm;
				opc8_andm: op_next = op_andm;
				default: op_next = op_bad; // dropped bb, call, setsp
			endcase
		end
		else if (is_i3)
		begin
			case (opc3)
				opc3_shl: op_next = op_shl;
				opc3_shlo: op_next = op_shlo;
				opc3_shr: op_next = op_shr;
				opc3_asr: op_next = op_asr;
				opc3_out: op_next = op_out;
				default: op_next = op_bad;
			endcase
		end
		else
		begin
			case (opc0)
				opc0_not: op_next = op_not;
				opc0_test: op_next = op_test;
				opc0_nop: op_next = op_nop;
				default: op_next = op_bad; // mov, return etc
			endcase
		end
	end

	// full byte for i8, zero-extended shift amount otherwise
	assign imm_next = is_i8 ? i_instr[data_width-1:0]
		: {{(data_width-imm3_width){1'b0}}, i_instr[imm3_width-1:0]};

	assign uses_mem = (op_next inside {op_addm, op_subm, op_orm, op_andm, op_ldm});
	assign o_mem_radr = i_instr[dmem_adr_width-1:0]; // address wraps at 16 words

	assign o_ready = !o_valid || i_ready;
	assign load = i_valid && o_ready;

	always_ff @(posedge clk)
	begin
		if (reset || i_flush)
			o_valid <= 1'b0;
		else if (load)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0; // execute took the last one
	end

	// payload towards execute
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			o_op <= op_next;
			o_cond <= cond_e'(i_instr[cond_lsb +: 2]);
			o_imm <= imm_next;
			o_mem_data <= uses_mem ? i_mem_rdata : '0;
			o_pc <= i_pc; // bf target base
		end
	end

endmodule

`default_nettype wire

// File: source/pat_execute.sv
`default_nettype none

module pat_execute (
	input wire clk,
	input wire reset,
	// from decode
	input wire i_valid,
	output logic o_ready,
	input wire pat_pkg::op_e i_op,
	input wire pat_pkg::cond_e i_cond,
	input wire pat_pkg::data_t i_imm,
	input wire pat_pkg::data_t i_mem_data,
	input wire pat_pkg::pc_t i_pc,
	// branch redirect to fetch and decode
	output logic o_redirect,
	output pat_pkg::pc_t o_target,
	// store to data memory
	output logic o_wr_en,
	output logic [pat_pkg::dmem_adr_width-1:0] o_wr_adr,
	output pat_pkg::data_t o_wr_data,
	// out port
	output logic o_out_valid,
	output pat_pkg::data_t o_out_data,
	input wire i_out_ready
);
	import pat_pkg::*;

	data_t acc; // accumulator
	logic z; // zero flag
	logic n; // negative flag
	data_t alu_b;
	data_t alu_y;
	logic commit; // instruction retires on this edge
	logic writes_acc;
	logic cond_ok;

	// ======================================================================
	// commit control
	// ======================================================================
	assign o_ready = !(o_out_valid && !i_out_ready); // out register full and held
	assign commit = i_valid && o_ready;

	assign alu_b = (i_op inside {op_addm, op_subm, op_orm, op_andm, op_ldm}) ? i_mem_data : i_imm;

	assign writes_acc = (i_op inside {op_or, op_and, op_add, op_sub, op_addm, op_subm,
		op_orm, op_andm, op_ldi, op_ldm, op_shl, op_shlo, op_shr, op_asr, op_not});

	always_comb
	begin
		case (i_cond)
			cond_zero: cond_ok = z;
			cond_neg: cond_ok = n;
			default: cond_ok = 1'b1; // both always codes
		endcase
	end

	// taken bf, relative to its own pc
	assign o_redirect = commit && (i_op == op_bf) && cond_ok;
	assign o_target = i_pc + {{(pc_width-data_width){i_imm[data_width-1]}}, i_imm};

	pat_alu u_alu (
		.i_a(acc),
		.i_b(alu_b),
		.i_op(i_op),
		.o_y(alu_y)
	);

	// architectural state
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
		end
		else if (commit)
		begin
			if (writes_acc)
				acc <= alu_y;
			if (i_op == op_test)
			begin
				z <= (acc == '0);
				n <= acc[data_width-1];
			end
		end
	end

	// stm, lands in memory on the following edge
	always_ff @(posedge clk)
	begin
		if (reset)
			o_wr_en <= 1'b0;
		else
			o_wr_en <= commit && (i_op == op_stm);
	end

	always_ff @(posedge clk)
	begin
		if (commit && (i_op == op_stm))
		begin
			o_wr_adr <= i_imm[dmem_adr_width-1:0];
			o_wr_data <= acc;
		end
	end

	// ======================================================================
	// out port
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			o_out_valid <= 1'b0;
		else if (commit && (i_op == op_out))
			o_out_valid <= 1'b1; // may replace a value taken this edge
		else if (i_out_ready)
			o_out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (commit && (i_op == op_out))
			o_out_data <= acc;
	end

	// a stalled value holds until the consumer takes it
	a_out_stable : assert property (
		@(posedge clk) disable iff (reset)
		(o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data))
	);

endmodule

`default_nettype wire

// File: test/pat_model.svh
`ifndef pat_model_svh
`define pat_model_svh

// ======================================================================
// instruction-set model state
// ======================================================================
data_t m_acc; // model accumulator
logic m_z; // zero flag, only test writes it
logic m_n; // negative flag
int m_pc;
data_t m_mem [16]; // data words, 4-bit address
logic [15:0] m_written; // words that hold a stored value
instr_t prog [prog_len]; // generated program
data_t exp_q [$]; // expected out values in order

function automatic int rand_below(int n);
	return int'($unsigned($random(seed)) % n);
endfunction

// encoders, unused fields stay zero
function automatic instr_t i8_word(logic [3:0] opc, data_t imm, logic [1:0] cond);
	return {5'b0, cond, 1'b0, opc, imm};
endfunction

function automatic instr_t i3_word(logic [3:0] opc, logic [2:0] amount);
	return {8'b0, prefix_ext, opc, 1'b0, amount};
endfunction

function automatic instr_t i0_word(logic [3:0] opc);
	return {8'b0, prefix_ext, prefix_ext, opc};
endfunction

// one instruction of the reference machine
function automatic void step_model(instr_t w);
	logic [3:0] opc8;
	logic [3:0] opc3;
	logic [2:0] sh;
	data_t imm;
	data_t mval;
	logic take;
	opc8 = w[11:8];
	opc3 = w[7:4];
	sh = w[2:0];
	imm = w[7:0];
	mval = m_mem[imm[3:0]]; // address wraps at 16
	take = 1'b0;
	if (opc8 != prefix_ext)
	begin
		case (opc8)
			opc8_or: m_acc = m_acc | imm;
			opc8_and: m_acc = m_acc & imm;
			opc8_add: m_acc = m_acc + imm; // wraps at 8 bits
			opc8_sub: m_acc = m_acc - imm;
			opc8_orm: m_acc = m_acc | mval;
			opc8_andm: m_acc = m_acc & mval;
			opc8_addm: m_acc = m_acc + mval;
			opc8_subm: m_acc = m_acc - mval;
			opc8_ldi: m_acc = imm;
			opc8_ldm: m_acc = mval;
			opc8_stm:
			begin
				m_mem[imm[3:0]] = m_acc;
				m_written[imm[3:0]] = 1'b1;
			end
			opc8_bf:
			begin
				case (w[14:13])
					2'b00: take = m_z;
					2'b01: take = m_n;
					default: take = 1'b1; // always
				endcase
			end
			default: ;
		endcase
	end
	else if (opc3 != prefix_ext)
	begin
		case (opc3)
			opc3_shl: m_acc = m_acc << sh;
			opc3_shlo: m_acc = (m_acc << sh) | data_t'((16'd1 << sh) - 16'd1); // ones shifted in
			opc3_shr: m_acc = m_acc >> sh;
			opc3_asr: m_acc = data_t'($signed(m_acc) >>> sh);
			opc3_out: exp_q.push_back(m_acc);
			default: ;
		endcase
	end
	else if (w[3:0] == opc0_not)
		m_acc = ~m_acc;
	else if (w[3:0] == opc0_test)
	begin
		m_z = (m_acc == 8'h00);
		m_n = m_acc[7];
	end
	m_pc = take ? m_pc + int'($signed(imm)) : m_pc + 1; // bf is relative to its own pc
endfunction

// ======================================================================
// random program, run through the model while it is built
// ======================================================================
function automatic void generate_program();
	int kind;
	int off;
	data_t imm;
	logic [3:0] adr;
	logic live; // model pc sits here, so this word will run
	logic prev_stm;
	instr_t w;
	m_acc = '0;
	m_z = 1'b0;
	m_n = 1'b0;
	m_pc = 0;
	m_written = '0;
	prev_stm = 1'b0;
	for (int i = 0; i < prog_len - 1; i++)
	begin
		live = (m_pc == i);
		kind = rand_below(16);
		imm = data_t'(rand_below(256));
		// no load right after stm, and a live load needs a stored word
		if ((kind == 10 || kind == 11) && (prev_stm || (live && m_written == '0)))
			kind = 0;
		if ((kind == 10 || kind == 11) && live)
		begin
			do
				adr = 4'(rand_below(16));
			while (!m_written[adr]);
			imm[3:0] = adr; // high nibble stays random
		end
		case (kind)
			0: w = i8_word(opc8_ldi, imm, 2'b00);
			1: w = i8_word(opc8_add, imm, 2'b00);
			2: w = i8_word(opc8_sub, imm, 2'b00);
			3: w = i8_word(opc8_or, imm, 2'b00);
			4: w = i8_word(opc8_and, imm, 2'b00);
			5: w = i0_word(opc0_not);
			6:
			begin
				case (rand_below(4))
					0: w = i3_word(opc3_shl, 3'(rand_below(8)));
					1: w = i3_word(opc3_shlo, 3'(rand_below(8)));
					2: w = i3_word(opc3_shr, 3'(rand_below(8)));
					default: w = i3_word(opc3_asr, 3'(rand_below(8)));
				endcase
			end
			9: w = i8_word(opc8_stm, imm, 2'b00);
			10: w = i8_word(opc8_ldm, imm, 2'b00);
			11:
			begin
				case (rand_below(4))
					0: w = i8_word(opc8_addm, imm, 2'b00);
					1: w = i8_word(opc8_subm, imm, 2'b00);
					2: w = i8_word(opc8_orm, imm, 2'b00);
					default: w = i8_word(opc8_andm, imm, 2'b00);
				endcase
			end
			12: w = i0_word(opc0_test);
			13:
			begin
				off = 1 + rand_below(3); // forward only
				if (off > prog_len - 1 - i)
					off = prog_len - 1 - i;
				w = i8_word(opc8_bf, data_t'(off), 2'(rand_below(4)));
			end
			14: w = i0_word(opc0_nop);
			default: w = i3_word(opc3_out, 3'd0); // 7, 8, 15
		endcase
		prog[i] = w;
		prev_stm = (kind == 9);
		if (live)
			step_model(w);
	end
	prog[prog_len-1] = i8_word(opc8_bf, 8'h00, 2'b10); // halt, branch to itself
endfunction

`endif

// File: test/pat_tb.sv
`default_nettype none

module pat_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pat_pkg::*;

	localparam int prog_len = 60; // words, halt included
	localparam int reset_cycles = (prog_len > 16) ? prog_len : 16; // load fits inside reset
	localparam int drain_cycles = 3 * prog_len + 20; // run on to the halt after the last out
	localparam int timeout_cycles = reset_cycles + 40 * prog_len + drain_cycles;

	logic clk;
	logic reset;
	logic i_imem_wr_en;
	pc_t i_imem_wr_addr;
	instr_t i_imem_wr_data;
	logic i_out_ready;
	logic o_out_valid;
	data_t o_out_data;

	int seed;
	int errors;
	int recv_count; // out values taken by the consumer
	int exp_total;
	logic stalled; // value offered last cycle and not taken
	data_t held_data;

	`include "pat_model.svh"

	pat_core #(
		.imem_depth(256),
		.dmem_depth(16)
	) UUT (
		.clk(clk),
		.reset(reset),
		.i_imem_wr_en(i_imem_wr_en),
		.i_imem_wr_addr(i_imem_wr_addr),
		.i_imem_wr_data(i_imem_wr_data),
		.i_out_ready(i_out_ready),
		.o_out_valid(o_out_valid),
		.o_out_data(o_out_data)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			$display("mismatch %s got 0x%0h expected 0x%0h", name, got, expected);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("errors %0d, out values %0d of %0d", errors, recv_count, exp_total);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// ======================================================================
	// reset, program load and end of run
	// ======================================================================
	initial
	begin
		reset = 1'b1;
		i_imem_wr_en = 1'b0;
		i_imem_wr_addr = '0;
		i_imem_wr_data = '0;
		errors = 0;
		recv_count = 0;
		seed = 29286;
		generate_program();
		exp_total = exp_q.size();
		for (int i = 0; i < reset_cycles; i++)
		begin
			@(negedge clk);
			i_imem_wr_en <= (i < prog_len);
			i_imem_wr_addr <= pc_t'(i);
			i_imem_wr_data <= (i < prog_len) ? prog[i] : nop_word;
		end
		@(negedge clk);
		i_imem_wr_en <= 1'b0;
		reset <= 1'b0; // first fetch from pc 0
		while (recv_count < exp_total)
			@(negedge clk);
		repeat (drain_cycles) @(negedge clk); // catches extra values before and at the halt
		compare_value("out_count", 32'(recv_count), 32'(exp_total));
		finish_run();
	end

	// out port consumer with random ready
	initial
	begin
		i_out_ready = 1'b0;
		stalled = 1'b0;
		held_data = '0;
		forever
		begin
			@(negedge clk);
			if (reset)
				compare_value("out_valid", 32'(o_out_valid), 32'd0);
			else
			begin
				if (stalled)
				begin
					compare_value("out_valid", 32'(o_out_valid), 32'd1);
					compare_value("out_data_held", 32'(o_out_data), 32'(held_data));
				end
				i_out_ready = (rand_below(2) == 1);
				if (o_out_valid && i_out_ready) // taken on the next rising edge
				begin
					if (exp_q.size() == 0)
					begin
						$display("out value 0x%0h arrived with no value left in the model",
							o_out_data);
						errors++;
					end
					else
						compare_value("out_data", 32'(o_out_data), 32'(exp_q.pop_front()));
					recv_count++;
				end
				stalled = o_out_valid && !i_out_ready;
				held_data = o_out_data;
			end
		end
	end

	// watchdog, 40 cycles per instruction plus load and drain
	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout waiting for out values");
		errors++;
		finish_run();
	end

endmodule

`default_nettype wire
